// File: hdl/graphicsOverlayPkg.sv
package graphicsOverlayPkg;

  typedef logic [10:0] pixelIndexT;
  typedef logic [9:0] lineIndexT;
  typedef logic [9:0] readCountT;
  typedef logic [8:0] bufferAddrT;
  typedef logic [31:0] lineWordT;
  typedef logic [15:0] rgb565T;
  typedef logic [7:0] grayT;

  // 720p raster, graphics live in the right half
  localparam pixelIndexT halfScreen = 11'd640;
  localparam lineIndexT verticalScreenSize = 10'd720;

  // colour outside the graphics window
  localparam logic [4:0] borderRed = 5'd7;
  localparam logic [5:0] borderGreen = 6'd15;
  localparam logic [4:0] borderBlue = 5'd7;

  // cycles from raster inputs to video outputs
  localparam int pipelineDepth = 3;

  typedef struct packed {
    pixelIndexT pixelIndex;
    lineIndexT lineIndex;
    logic requestPixel;
    logic hSync;
    logic vSync;
    logic nextLine;
  } videoTimingT;

  typedef struct packed {
    logic writeEnable;
    bufferAddrT address;
    lineWordT data;
  } bufferWriteT;

  typedef struct packed {
    logic dualPixel;
    logic grayscale;
  } pixelModeT;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    logic hSync;
    logic vSync;
    logic active;
  } videoOutT;

endpackage

// File: hdl/lineFill.sv
module lineFill (
  input logic pixelClockIn,
  input logic rst,
  input logic wordValid,
  input graphicsOverlayPkg::lineWordT wordData,
  input logic lineDone,
  output graphicsOverlayPkg::bufferWriteT write,
  output logic writeBank
);

  graphicsOverlayPkg::bufferAddrT fillAddress;

  // fill pointer and bank select
  always_ff @(posedge pixelClockIn)
  begin
    if (rst)
    begin
      fillAddress <= '0;
      writeBank <= 1'b0;
    end
    else if (lineDone)
    begin
      // display finished its line, swap banks and restart the fill
      fillAddress <= '0;
      writeBank <= ~writeBank;
    end
    else if (wordValid)
    begin
      // wraps after 512 words
      fillAddress <= fillAddress + 1'b1;
    end
  end

  // each strobe is one write at the current pointer
  always_comb
  begin
    write.writeEnable = wordValid;
    write.address = fillAddress;
    write.data = wordData;
  end

endmodule

// File: hdl/lineBuffer.sv
module lineBuffer (
  input logic pixelClockIn,
  input graphicsOverlayPkg::bufferWriteT write,
  input logic writeBank,
  input graphicsOverlayPkg::bufferAddrT readAddress,
  output graphicsOverlayPkg::lineWordT readWord
);

  graphicsOverlayPkg::lineWordT bank0 [0:2**$bits(graphicsOverlayPkg::bufferAddrT)-1];
  graphicsOverlayPkg::lineWordT bank1 [0:2**$bits(graphicsOverlayPkg::bufferAddrT)-1];
  graphicsOverlayPkg::lineWordT bank0Word;
  graphicsOverlayPkg::lineWordT bank1Word;
  logic readBank;

  // bank 0, written while writeBank is low
  always_ff @(posedge pixelClockIn)
  begin
    if (write.writeEnable && !writeBank)
    begin
      bank0[write.address] <= write.data;
    end
    bank0Word <= bank0[readAddress];
  end

  // bank 1, written while writeBank is high
  always_ff @(posedge pixelClockIn)
  begin
    if (write.writeEnable && writeBank)
    begin
      bank1[write.address] <= write.data;
    end
    bank1Word <= bank1[readAddress];
  end

  // display always reads the bank not being filled
  always_ff @(posedge pixelClockIn)
  begin
    readBank <= ~writeBank;
  end

  always_comb
  begin
    readWord = readBank ? bank1Word : bank0Word;
  end

endmodule

// File: hdl/windowTracker.sv
module windowTracker (
  input logic pixelClockIn,
  input logic rst,
  input graphicsOverlayPkg::videoTimingT timing,
  input graphicsOverlayPkg::readCountT graphicsWidth,
  input graphicsOverlayPkg::lineIndexT graphicsHeight,
  input graphicsOverlayPkg::pixelModeT mode,
  output graphicsOverlayPkg::bufferAddrT readAddress,
  output logic [1:0] wordLane,
  output logic [2:0] inWindow,
  output logic lineDone
);

  graphicsOverlayPkg::pixelIndexT leftMargin;
  graphicsOverlayPkg::pixelIndexT lineBegin;
  graphicsOverlayPkg::pixelIndexT lineEnd;
  graphicsOverlayPkg::lineIndexT topMargin;
  graphicsOverlayPkg::lineIndexT screenEnd;
  graphicsOverlayPkg::readCountT readCount;
  graphicsOverlayPkg::readCountT shiftedCount;
  logic [1:0] laneStage;
  logic [1:0] windowDelay;
  logic windowHit;

  // window is centred in the right half and vertically on the screen
  always_comb
  begin
    leftMargin = (graphicsOverlayPkg::halfScreen - {1'b0, graphicsWidth}) >> 1;
    lineBegin = graphicsOverlayPkg::halfScreen + leftMargin;
    lineEnd = lineBegin + {1'b0, graphicsWidth};
    topMargin = (graphicsOverlayPkg::verticalScreenSize - graphicsHeight) >> 1;
    screenEnd = topMargin + graphicsHeight;
  end

  always_comb
  begin
    windowHit = (timing.lineIndex >= topMargin) && (timing.lineIndex < screenEnd) &&
                (timing.pixelIndex >= lineBegin) && (timing.pixelIndex < lineEnd) &&
                timing.requestPixel;
  end

  // stage 0 is the raw hit, stages 1 and 2 follow the buffer read
  assign inWindow = {windowDelay, windowHit};

  always_ff @(posedge pixelClockIn)
  begin
    if (rst)
    begin
      readCount <= '0;
      windowDelay <= '0;
      lineDone <= 1'b0;
    end
    else
    begin
      if (timing.nextLine)
        readCount <= '0;
      else if (windowHit)
        readCount <= readCount + 1'b1;
      windowDelay <= {windowDelay[0], windowHit};
      // one cycle after the window flag drops
      lineDone <= windowDelay[1] & ~windowDelay[0];
    end
  end

  // pixels per word: 2 colour, 4 gray, doubled halves the rate again
  always_comb
  begin
    unique case ({mode.grayscale, mode.dualPixel})
      2'b00: shiftedCount = readCount >> 1;
      2'b11: shiftedCount = readCount >> 3;
      default: shiftedCount = readCount >> 2;
    endcase
  end

  // count still holds the index of the current pixel here
  always_ff @(posedge pixelClockIn)
  begin
    readAddress <= shiftedCount[8:0];
    laneStage <= mode.dualPixel ? readCount[2:1] : readCount[1:0];
    // lane has to line up with the registered buffer output
    wordLane <= laneStage;
  end

endmodule

// File: hdl/pixelFormatter.sv
module pixelFormatter (
  input logic pixelClockIn,
  input logic rst,
  input graphicsOverlayPkg::videoTimingT timing,
  input graphicsOverlayPkg::pixelModeT mode,
  input graphicsOverlayPkg::lineWordT readWord,
  input logic [1:0] wordLane,
  input logic [2:0] inWindow,
  output graphicsOverlayPkg::videoOutT video
);

  logic [graphicsOverlayPkg::pipelineDepth-2:0] hSyncDelay;
  logic [graphicsOverlayPkg::pipelineDepth-2:0] vSyncDelay;
  logic [graphicsOverlayPkg::pipelineDepth-2:0] activeDelay;
  graphicsOverlayPkg::rgb565T colourPixel;
  graphicsOverlayPkg::grayT grayPixel;
  graphicsOverlayPkg::rgb565T shownPixel;
  graphicsOverlayPkg::videoOutT videoReg;

  // low half-word is the first colour pixel
  always_comb
  begin
    colourPixel = wordLane[0] ? readWord[31:16] : readWord[15:0];
  end

  // gray bytes go out lowest first
  always_comb
  begin
    unique case (wordLane)
      2'd0: grayPixel = readWord[7:0];
      2'd1: grayPixel = readWord[15:8];
      2'd2: grayPixel = readWord[23:16];
      default: grayPixel = readWord[31:24];
    endcase
  end

  // gray to RGB565 by taking the top bits per channel
  always_comb
  begin
    if (mode.grayscale)
      shownPixel = {grayPixel[7:3], grayPixel[7:2], grayPixel[7:3]};
    else
      shownPixel = colourPixel;
  end

  always_ff @(posedge pixelClockIn)
  begin
    if (inWindow[2])
    begin
      videoReg.red <= shownPixel[15:11];
      videoReg.green <= shownPixel[10:5];
      videoReg.blue <= shownPixel[4:0];
    end
    else
    begin
      videoReg.red <= graphicsOverlayPkg::borderRed;
      videoReg.green <= graphicsOverlayPkg::borderGreen;
      videoReg.blue <= graphicsOverlayPkg::borderBlue;
    end

    // syncs travel alongside the pixel data, last stage is videoReg
    if (rst)
    begin
      hSyncDelay <= '0;
      vSyncDelay <= '0;
      activeDelay <= '0;
      videoReg.hSync <= 1'b0;
      videoReg.vSync <= 1'b0;
      videoReg.active <= 1'b0;
    end
    else
    begin
      hSyncDelay <= {hSyncDelay[graphicsOverlayPkg::pipelineDepth-3:0], timing.hSync};
      vSyncDelay <= {vSyncDelay[graphicsOverlayPkg::pipelineDepth-3:0], timing.vSync};
      activeDelay <= {activeDelay[graphicsOverlayPkg::pipelineDepth-3:0], timing.requestPixel};
      videoReg.hSync <= hSyncDelay[graphicsOverlayPkg::pipelineDepth-2];
      videoReg.vSync <= vSyncDelay[graphicsOverlayPkg::pipelineDepth-2];
      videoReg.active <= activeDelay[graphicsOverlayPkg::pipelineDepth-2];
    end
  end

  assign video = videoReg;

endmodule

// File: hdl/graphicsOverlay.sv
module graphicsOverlay (
  input logic pixelClockIn,
  input logic rst,
  input graphicsOverlayPkg::videoTimingT timing,
  input logic wordValid,
  input graphicsOverlayPkg::lineWordT wordData,
  input graphicsOverlayPkg::readCountT graphicsWidth,
  input graphicsOverlayPkg::lineIndexT graphicsHeight,
  input graphicsOverlayPkg::pixelModeT mode,
  output graphicsOverlayPkg::videoOutT video,
  output logic lineDone
);

  graphicsOverlayPkg::bufferWriteT bufferWrite;
  graphicsOverlayPkg::bufferAddrT readAddress;
  graphicsOverlayPkg::lineWordT readWord;
  logic writeBank;
  logic [1:0] wordLane;
  logic [2:0] inWindow;

  lineFill i_lineFill (
    .pixelClockIn(pixelClockIn),
    .rst(rst),
    .wordValid(wordValid),
    .wordData(wordData),
    .lineDone(lineDone),
    .write(bufferWrite),
    .writeBank(writeBank)
  );

  lineBuffer i_lineBuffer (
    .pixelClockIn(pixelClockIn),
    .write(bufferWrite),
    .writeBank(writeBank),
    .readAddress(readAddress),
    .readWord(readWord)
  );

  windowTracker i_windowTracker (
    .pixelClockIn(pixelClockIn),
    .rst(rst),
    .timing(timing),
    .graphicsWidth(graphicsWidth),
    .graphicsHeight(graphicsHeight),
    .mode(mode),
    .readAddress(readAddress),
    .wordLane(wordLane),
    .inWindow(inWindow),
    .lineDone(lineDone)
  );

  pixelFormatter i_pixelFormatter (
    .pixelClockIn(pixelClockIn),
    .rst(rst),
    .timing(timing),
    .mode(mode),
    .readWord(readWord),
    .wordLane(wordLane),
    .inWindow(inWindow),
    .video(video)
  );

endmodule

// File: test/graphicsOverlayTb.sv
module graphicsOverlayTb;

  timeunit 1ns;
  timeprecision 1ps;

  logic pixelClockIn;
  logic rst;
  graphicsOverlayPkg::videoTimingT timing;
  logic wordValid;
  graphicsOverlayPkg::lineWordT wordData;
  graphicsOverlayPkg::readCountT graphicsWidth;
  graphicsOverlayPkg::lineIndexT graphicsHeight;
  graphicsOverlayPkg::pixelModeT mode;
  graphicsOverlayPkg::videoOutT video;
  logic lineDone;

  // per-case configuration read from the vectors file
  graphicsOverlayPkg::pixelModeT caseMode[$];
  int caseWidth[$];
  int caseHeight[$];
  int caseWordBase[$];
  int caseWordCount[$];
  int caseSampleBase[$];
  int caseSampleCount[$];
  graphicsOverlayPkg::lineWordT wordStore[$];
  int samplePixel[$];
  int sampleLine[$];
  graphicsOverlayPkg::rgb565T sampleColour[$];

  // raster entries waiting for their output
  graphicsOverlayPkg::videoTimingT timingQ[$];
  int caseQ[$];

  int videoErrors = 0;
  int pulseErrors = 0;
  longint watchdogCycles = 0;

  graphicsOverlay i_graphicsOverlay (
    .pixelClockIn(pixelClockIn),
    .rst(rst),
    .timing(timing),
    .wordValid(wordValid),
    .wordData(wordData),
    .graphicsWidth(graphicsWidth),
    .graphicsHeight(graphicsHeight),
    .mode(mode),
    .video(video),
    .lineDone(lineDone)
  );

  initial
  begin
    pixelClockIn = 1'b0;
    forever #10 pixelClockIn = ~pixelClockIn;
  end

  task automatic checkVideo(input graphicsOverlayPkg::videoOutT expected,
                            input graphicsOverlayPkg::videoOutT actual,
                            input bit withColour, input string what);
    bit bad;
    bad = (actual.hSync !== expected.hSync) || (actual.vSync !== expected.vSync) ||
          (actual.active !== expected.active);
    if (withColour)
      bad = bad || (actual.red !== expected.red) || (actual.green !== expected.green) ||
            (actual.blue !== expected.blue);
    if (bad)
    begin
      videoErrors++;
      $display("** Error at %0t: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  task automatic checkPulse(input logic expected, input logic actual, input string what);
    if (actual !== expected)
    begin
      pulseErrors++;
      $display("** Error at %0t: %s expected %b got %b", $time, what, expected, actual);
    end
  endtask

  // output at this negedge belongs to the entry driven three edges ago
  task automatic checkOldest();
    graphicsOverlayPkg::videoTimingT e;
    graphicsOverlayPkg::videoOutT expected;
    int c;
    bit withColour;
    string what;
    if (timingQ.size() <= graphicsOverlayPkg::pipelineDepth)
      return;
    e = timingQ.pop_front();
    c = caseQ.pop_front();
    expected = '0;
    expected.hSync = e.hSync;
    expected.vSync = e.vSync;
    expected.active = e.requestPixel;
    withColour = 0;
    if (c >= 0)
    begin
      for (int s = caseSampleBase[c]; s < caseSampleBase[c] + caseSampleCount[c]; s++)
      begin
        if (e.pixelIndex == samplePixel[s] && e.lineIndex == sampleLine[s])
        begin
          withColour = 1;
          expected.red = sampleColour[s][15:11];
          expected.green = sampleColour[s][10:5];
          expected.blue = sampleColour[s][4:0];
        end
      end
    end
    what = $sformatf("case %0d pixel %0d line %0d", c, e.pixelIndex, e.lineIndex);
    checkVideo(expected, video, withColour, what);
  endtask

  task automatic driveCycle(input graphicsOverlayPkg::videoTimingT t, input int c,
                            input logic valid, input graphicsOverlayPkg::lineWordT data,
                            inout int pulses);
    @(posedge pixelClockIn);
    timing <= t;
    wordValid <= valid;
    wordData <= data;
    timingQ.push_back(t);
    caseQ.push_back(c);
    @(negedge pixelClockIn);
    if (lineDone === 1'b1)
      pulses++;
    checkOldest();
  endtask

  // one full raster line, loading the case words on window lines
  task automatic sweepLine(input int c, input int line);
    graphicsOverlayPkg::videoTimingT t;
    int pulses;
    int top;
    logic windowLine;
    logic seen;
    logic valid;
    graphicsOverlayPkg::lineWordT data;
    pulses = 0;
    top = (720 - caseHeight[c]) / 2;
    windowLine = (line >= top) && (line < top + caseHeight[c]);
    for (int p = 0; p < 1280; p++)
    begin
      t.pixelIndex = p;
      t.lineIndex = line;
      t.requestPixel = (p >= graphicsOverlayPkg::halfScreen);
      t.hSync = (p >= 1100) && (p < 1140);
      t.vSync = line[0];
      t.nextLine = (p == 0);
      valid = windowLine && (p < caseWordCount[c]);
      data = valid ? wordStore[caseWordBase[c] + p] : '0;
      driveCycle(t, c, valid, data, pulses);
    end
    seen = (pulses == 0) ? 1'b0 : (pulses == 1) ? 1'b1 : 1'bx;
    checkPulse(windowLine, seen, $sformatf("lineDone on case %0d line %0d", c, line));
  endtask

  task automatic readVectors(output bit ok);
    int fd;
    int code;
    int dual;
    int gray;
    int width;
    int height;
    int nWords;
    int nSamples;
    int px;
    int ln;
    logic [31:0] value;
    string header;
    ok = 0;
    fd = $fopen("test/overlay_vectors.txt", "r");
    if (fd == 0)
      return;
    code = $fgets(header, fd);
    code = $fgets(header, fd);
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%d %d %d %d %d %d", dual, gray, width, height, nWords, nSamples);
      if (code != 6)
        break;
      caseMode.push_back('{dualPixel: dual[0], grayscale: gray[0]});
      caseWidth.push_back(width);
      caseHeight.push_back(height);
      caseWordBase.push_back(wordStore.size());
      caseWordCount.push_back(nWords);
      caseSampleBase.push_back(samplePixel.size());
      caseSampleCount.push_back(nSamples);
      for (int i = 0; i < nWords; i++)
      begin
        code = $fscanf(fd, "%h", value);
        wordStore.push_back(value);
      end
      for (int i = 0; i < nSamples; i++)
      begin
        code = $fscanf(fd, "%d %d %h", px, ln, value);
        samplePixel.push_back(px);
        sampleLine.push_back(ln);
        sampleColour.push_back(value[15:0]);
      end
    end
    $fclose(fd);
    ok = (caseMode.size() > 0);
  endtask

  initial
  begin
    wait (watchdogCycles > 0);
    #(watchdogCycles * 20 + 20000);
    $display("timeout: the run did not finish within the expected time");
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    bit ok;
    int top;
    int totalLines;
    int pulses;
    rst = 1'b1;
    timing = '0;
    wordValid = 1'b0;
    wordData = '0;
    graphicsWidth = '0;
    graphicsHeight = '0;
    mode = '0;
    readVectors(ok);
    if (!ok)
    begin
      $display("could not open or parse test/overlay_vectors.txt");
      $display("Testbench failed");
      $finish;
    end
    else
    begin
      totalLines = 0;
      foreach (caseHeight[c])
        totalLines += caseHeight[c] + 2;
      watchdogCycles = longint'(totalLines) * 1300;
      repeat (5) @(posedge pixelClockIn);
      rst <= 1'b0;
      @(negedge pixelClockIn);
      checkVideo('0, video, 0, "syncs and active after reset");
      checkPulse(1'b0, lineDone, "lineDone after reset");
      foreach (caseMode[c])
      begin
        @(posedge pixelClockIn);
        mode <= caseMode[c];
        graphicsWidth <= caseWidth[c];
        graphicsHeight <= caseHeight[c];
        // the raster holds its last value during this cycle
        timingQ.push_back(timing);
        caseQ.push_back(-1);
        @(negedge pixelClockIn);
        checkOldest();
        top = (720 - caseHeight[c]) / 2;
        for (int line = top - 1; line <= top + caseHeight[c]; line++)
          sweepLine(c, line);
      end
      // drain the pipeline with an idle raster
      pulses = 0;
      repeat (graphicsOverlayPkg::pipelineDepth)
        driveCycle('0, -1, 1'b0, '0, pulses);
      $display("video errors %0d, lineDone errors %0d", videoErrors, pulseErrors);
      if (videoErrors + pulseErrors == 0)
        $display("Testbench passed");
      else
        $display("Testbench failed");
      $finish;
    end
  end

endmodule

// File: test/overlay_vectors.txt
# case line: dualPixel grayscale width height wordCount sampleCount, then the line words (hex)
# sample line: pixelIndex lineIndex expected RGB565 (hex)
0 0 8 2 4 8
22221111 44443333 66665555 88887777
955 360 39e7
956 360 1111
957 360 2222
960 360 5555
963 360 8888
964 360 39e7
956 358 39e7
956 361 39e7
0 1 8 2 2 7
40302010 f0e0d0c0
956 360 1082
957 360 2104
958 360 3186
959 360 4208
960 360 c618
963 360 f79e
956 361 39e7
1 0 8 2 2 7
bbbbaaaa ddddcccc
956 360 aaaa
957 360 aaaa
958 360 bbbb
959 360 bbbb
962 360 dddd
963 360 dddd
964 360 39e7
1 1 8 4 1 8
80604020
956 357 39e7
956 359 2104
957 359 2104
958 359 4208
960 361 630c
963 361 8410
956 362 39e7
955 360 39e7

// File: graphicsOverlay.f
hdl/graphicsOverlayPkg.sv
hdl/lineFill.sv
hdl/lineBuffer.sv
hdl/windowTracker.sv
hdl/pixelFormatter.sv
hdl/graphicsOverlay.sv
test/graphicsOverlayTb.sv
